//--- project.f
source/morse_pkg.sv
source/key_sampler.sv
source/press_sequencer.sv
source/symbol_collector.sv
source/morse_table.sv
source/morse_regs.sv
source/morse_decoder.sv
verification/morse_checker.sv
verification/morse_decoder_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the morse decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -j 0 --top-module morse_decoder_tb -f project.f; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vmorse_decoder_tb)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation passed"; then
	exit 0
else
	exit 1
fi

//--- verification/morse_decoder_tb.sv
`timescale 1ns/1ns

module morse_decoder_tb;

	localparam int SYNC_STAGES = 2;
	localparam int HALF_PERIOD = 50;		// 100 ns clock
	localparam int RESET_CYCLES = 16;
	localparam int N_CHARS = 200;
	localparam int CYCLES_PER_CHAR = 200;	// bound per keyed character
	localparam int TIMEOUT_NS = (N_CHARS * CYCLES_PER_CHAR + RESET_CYCLES) * 2 * HALF_PERIOD;
	localparam logic [31:0] SEED = 32'h86b6;
	localparam logic [31:0] TAPS = 32'h8020_0003;	// x^32 + x^22 + x^2 + x + 1

	logic clk;
	logic rst_n;
	logic [1:0] button_in;		// active low
	logic [3:0] switch_in;
	morse_pkg::host_req_t host;
	logic [morse_pkg::DATA_W-1:0] read_data;

	logic check_en;			// read on the bus, checker compares
	logic expect_stb;		// character keyed, checker updates its model
	logic [2:0] expect_len;
	logic [5:0] expect_syms;
	int error_count;
	int check_count;

	logic [31:0] lfsr_q;

	morse_decoder #(
		.SYNC_STAGES(SYNC_STAGES)
	) morse_decoder_i (
		.clk(clk),
		.rst_n(rst_n),
		.button_in(button_in),
		.switch_in(switch_in),
		.host(host),
		.read_data(read_data)
	);

	morse_checker morse_checker_i (
		.clk(clk),
		.rst_n(rst_n),
		.host(host),
		.read_data(read_data),
		.check_en(check_en),
		.expect_stb(expect_stb),
		.expect_len(expect_len),
		.expect_syms(expect_syms),
		.error_count(error_count),
		.check_count(check_count)
	);

	always #(HALF_PERIOD) clk = ~clk;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ TAPS;
		end
		return s >> 1;
	endfunction

	// one lfsr step per bit taken, msb first
	task automatic draw_bits(input int width, output int value);
		value = 0;
		for (int i = 0; i < width; i++) begin
			value = (value << 1) | int'(lfsr_q[0]);	// bit shifted out
			lfsr_q = lfsr_next(lfsr_q);
		end
	endtask

	task automatic read_reg(input logic [1:0] addr);
		host.write <= 1'b0;
		host.address <= addr;
		check_en <= 1'b1;
		@(posedge clk);
		check_en <= 1'b0;
	endtask

	task automatic write_reg(input logic [1:0] addr, input logic [7:0] data);
		host.write <= 1'b1;
		host.address <= addr;
		host.write_data <= data;
		@(posedge clk);
		host.write <= 1'b0;
	endtask

	// button 0 held 4..19 cycles, released 4..11
	task automatic key_symbol(input logic sym);
		int hold;
		int gap;
		int upper;
		draw_bits(4, hold);
		draw_bits(3, gap);
		draw_bits(3, upper);
		switch_in <= {3'(upper), sym};	// upper switch bits unused by the DUT
		button_in[0] <= 1'b0;
		repeat (4 + hold) @(posedge clk);
		button_in[0] <= 1'b1;
		repeat (4 + gap) @(posedge clk);
	endtask

	task automatic key_done();
		int hold;
		draw_bits(3, hold);
		button_in[1] <= 1'b0;
		repeat (4 + hold) @(posedge clk);
		button_in[1] <= 1'b1;
	endtask

	task automatic send_character();
		int len;
		int value;
		int spare;
		logic [5:0] syms;
		draw_bits(8, len);
		len = len % 7;		// 0..6, six overflows
		syms = '0;
		for (int i = 0; i < len; i++) begin
			draw_bits(1, value);
			syms[i] = value[0];
		end
		for (int i = 0; i < len; i++) begin
			key_symbol(syms[i]);
		end
		key_done();
		repeat (8) @(posedge clk);	// latch is long done by now
		expect_len <= 3'(len);
		expect_syms <= syms;
		expect_stb <= 1'b1;
		@(posedge clk);
		expect_stb <= 1'b0;
		read_reg(morse_pkg::REG_CHAR);
		read_reg(morse_pkg::REG_READY);
		write_reg(morse_pkg::REG_READY, 8'h00);	// host acknowledges
		read_reg(morse_pkg::REG_READY);
		draw_bits(1, value);
		if (value == 1) begin
			draw_bits(8, value);
			write_reg(morse_pkg::REG_CHAR, 8'(value));
			read_reg(morse_pkg::REG_CHAR);
		end
		draw_bits(1, value);
		if (value == 1) begin
			draw_bits(1, spare);
			draw_bits(8, value);
			write_reg(2'(2 + spare), 8'(value));	// spare 2 or 3
			read_reg(morse_pkg::REG_SPARE2);
			read_reg(morse_pkg::REG_SPARE3);
			read_reg(morse_pkg::REG_CHAR);	// must be untouched
		end
	endtask

	initial begin
		clk = 1'b0;
		rst_n <= 1'b0;
		button_in <= 2'b11;		// both released
		switch_in <= 4'h0;
		host <= '0;
		check_en <= 1'b0;
		expect_stb <= 1'b0;
		expect_len <= 3'd0;
		expect_syms <= 6'd0;
		lfsr_q = SEED;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		// reset contents of the whole window
		read_reg(morse_pkg::REG_READY);
		read_reg(morse_pkg::REG_CHAR);
		read_reg(morse_pkg::REG_SPARE2);
		read_reg(morse_pkg::REG_SPARE3);
		for (int c = 0; c < N_CHARS; c++) begin
			send_character();
		end
		repeat (2) @(posedge clk);	// last compare lands
		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0 && check_count > 0) begin
			$display("Simulation passed");
		end else begin
			if (check_count == 0) begin
				$display("no register reads were checked");
			end
			$display("Simulation failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("timeout, the character sequence did not finish within %0d ns", TIMEOUT_NS);
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- verification/morse_checker.sv
`timescale 1ns/1ns

module morse_checker (
	input logic clk,
	input logic rst_n,
	input morse_pkg::host_req_t host,
	input logic [7:0] read_data,
	input logic check_en,			// read cycle to compare
	input logic expect_stb,			// a character was keyed in
	input logic [2:0] expect_len,	// 0..6 symbols
	input logic [5:0] expect_syms,	// symbol i in bit i, dash is 1
	output int error_count,
	output int check_count
);

	// morse tree in heap order, root is node 1
	// a dot moves to node 2n, a dash to 2n+1, unused nodes hold "#"
	localparam logic [8*64-1:0] TREE = {
		"##",
		"ET",
		"IANM",
		"SURWDKGO",
		"HVF#L#PJBXCYZQ##",
		"54#3###2#######16#######7###8#90"
	};

	logic [7:0] model_ready;	// register 0 as the host should see it
	logic [7:0] model_char;		// register 1
	logic [7:0] expected;

	// walk the tree one symbol at a time
	function automatic logic [7:0] expected_char(input logic [2:0] len, input logic [5:0] syms);
		int node;
		node = 1;
		if (len == 3'd0 || len > 3'd5) begin
			return "#";		// empty or overflow
		end
		for (int i = 0; i < int'(len); i++) begin
			node = 2 * node + int'(syms[i]);
		end
		return TREE[8*(63-node) +: 8];
	endfunction

	// register map seen from the host
	always_comb begin
		case (host.address)
			2'd0: expected = model_ready;
			2'd1: expected = model_char;
			default: expected = 8'h00;	// spare addresses
		endcase
	end

	// sampled at the edge, so bus and read data are the settled values
	always @(posedge clk) begin
		if (!rst_n) begin
			model_ready <= 8'h00;
			model_char <= "#";
			error_count <= 0;
			check_count <= 0;
		end else begin
			if (check_en && !host.write) begin
				check_count <= check_count + 1;
				if (read_data !== expected) begin
					$display("Error: read_data at address %0d: expected 0x%02h, got 0x%02h",
						host.address, expected, read_data);
					error_count <= error_count + 1;
				end
			end
			if (expect_stb) begin
				model_char <= expected_char(expect_len, expect_syms);
				model_ready <= 8'h01;
			end else if (host.write) begin
				case (host.address)
					2'd0: model_ready <= host.write_data;
					2'd1: model_char <= host.write_data;
					default: ;	// writes to spares vanish
				endcase
			end
		end
	end

endmodule

//--- source/morse_decoder.sv
`timescale 1ns/1ns

module morse_decoder #(
	parameter int SYNC_STAGES = 2	// synchronizer depth, 1 or more
) (
	input logic clk,
	input logic rst_n,
	input logic [1:0] button_in,	// active low
	input logic [3:0] switch_in,
	input morse_pkg::host_req_t host,
	output logic [morse_pkg::DATA_W-1:0] read_data
);

	morse_pkg::keys_t keys;
	logic symbol_stb;
	morse_pkg::symbol_e symbol;
	logic done_stb;		// goes to collector and registers together
	morse_pkg::code_t code;
	logic [morse_pkg::DATA_W-1:0] char_code;

	// pins to clean key levels
	key_sampler #(
		.SYNC_STAGES(SYNC_STAGES)
	) key_sampler_i (
		.clk(clk),
		.rst_n(rst_n),
		.button_in(button_in),
		.switch_in(switch_in),
		.keys(keys)
	);

	press_sequencer press_sequencer_i (
		.clk(clk),
		.rst_n(rst_n),
		.keys(keys),
		.symbol_stb(symbol_stb),
		.symbol(symbol),
		.done_stb(done_stb)
	);

	symbol_collector symbol_collector_i (
		.clk(clk),
		.rst_n(rst_n),
		.symbol_stb(symbol_stb),
		.symbol(symbol),
		.done_stb(done_stb),
		.code(code)
	);

	// table output is sampled by the registers on done_stb
	morse_table morse_table_i (
		.code(code),
		.char_code(char_code)
	);

	morse_regs morse_regs_i (
		.clk(clk),
		.rst_n(rst_n),
		.done_stb(done_stb),
		.char_code(char_code),
		.host(host),
		.read_data(read_data)
	);

endmodule

//--- source/morse_regs.sv
`timescale 1ns/1ns

module morse_regs (
	input logic clk,
	input logic rst_n,
	input logic done_stb,
	input logic [morse_pkg::DATA_W-1:0] char_code,
	input morse_pkg::host_req_t host,
	output logic [morse_pkg::DATA_W-1:0] read_data
);

	logic [morse_pkg::DATA_W-1:0] ready_q;	// register 0
	logic [morse_pkg::DATA_W-1:0] char_q;	// register 1
	morse_pkg::reg_addr_e addr;

	assign addr = morse_pkg::reg_addr_e'(host.address);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ready_q <= '0;
			char_q <= morse_pkg::UNKNOWN_CHAR;
		end else if (done_stb) begin
			// a new character wins over a host write in the same cycle
			char_q <= char_code;
			ready_q <= morse_pkg::DATA_W'(1);
		end else if (host.write) begin
			case (addr)
				morse_pkg::REG_READY: ready_q <= host.write_data;	// host clears flag
				morse_pkg::REG_CHAR: char_q <= host.write_data;
				default: ;	// spare addresses drop writes
			endcase
		end
	end

	// asynchronous read
	always_comb begin
		case (addr)
			morse_pkg::REG_READY: read_data = ready_q;
			morse_pkg::REG_CHAR: read_data = char_q;
			default: read_data = '0;
		endcase
	end

endmodule

//--- source/morse_table.sv
`timescale 1ns/1ns

module morse_table (
	input morse_pkg::code_t code,
	output logic [morse_pkg::DATA_W-1:0] char_code
);

	// seq holds the first symbol in its msb so codes read left to right
	// dot is 0 and dash is 1, e.g. "A" (.-) is 2'b01
	logic [morse_pkg::MAX_SYMBOLS-1:0] seq;

	always_comb begin
		for (int i = 0; i < morse_pkg::MAX_SYMBOLS; i++) begin
			seq[morse_pkg::MAX_SYMBOLS-1-i] = code.pattern[i];
		end
	end

	always_comb begin
		char_code = morse_pkg::UNKNOWN_CHAR;	// empty, overflow, no match
		if (!code.overflow) begin
			case (code.len)
				3'd1: char_code = seq[4] ? "T" : "E";
				3'd2: begin
					case (seq[4:3])
						2'b01: char_code = "A";
						2'b00: char_code = "I";
						2'b11: char_code = "M";
						2'b10: char_code = "N";
						default: char_code = morse_pkg::UNKNOWN_CHAR;
					endcase
				end
				3'd3: begin
					case (seq[4:2])
						3'b100: char_code = "D";
						3'b110: char_code = "G";
						3'b101: char_code = "K";
						3'b111: char_code = "O";
						3'b010: char_code = "R";
						3'b000: char_code = "S";
						3'b001: char_code = "U";
						3'b011: char_code = "W";
						default: char_code = morse_pkg::UNKNOWN_CHAR;
					endcase
				end
				3'd4: begin
					// four of the sixteen codes have no letter
					case (seq[4:1])
						4'b1000: char_code = "B";
						4'b1010: char_code = "C";
						4'b0010: char_code = "F";
						4'b0000: char_code = "H";
						4'b0111: char_code = "J";
						4'b0100: char_code = "L";
						4'b0110: char_code = "P";
						4'b1101: char_code = "Q";
						4'b0001: char_code = "V";
						4'b1001: char_code = "X";
						4'b1011: char_code = "Y";
						4'b1100: char_code = "Z";
						default: char_code = morse_pkg::UNKNOWN_CHAR;
					endcase
				end
				3'd5: begin
					case (seq)	// digits only
						5'b11111: char_code = "0";
						5'b01111: char_code = "1";
						5'b00111: char_code = "2";
						5'b00011: char_code = "3";
						5'b00001: char_code = "4";
						5'b00000: char_code = "5";
						5'b10000: char_code = "6";
						5'b11000: char_code = "7";
						5'b11100: char_code = "8";
						5'b11110: char_code = "9";
						default: char_code = morse_pkg::UNKNOWN_CHAR;
					endcase
				end
				default: char_code = morse_pkg::UNKNOWN_CHAR;	// len 0
			endcase
		end
	end

endmodule

//--- source/symbol_collector.sv
`timescale 1ns/1ns

module symbol_collector (
	input logic clk,
	input logic rst_n,
	input logic symbol_stb,
	input morse_pkg::symbol_e symbol,
	input logic done_stb,
	output morse_pkg::code_t code
);

	localparam logic [morse_pkg::LEN_W-1:0] FULL = morse_pkg::LEN_W'(morse_pkg::MAX_SYMBOLS);
	localparam logic [morse_pkg::LEN_W-1:0] ONE = morse_pkg::LEN_W'(1);

	logic full;

	assign full = (code.len == FULL);	// buffer has no free slot

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			code.len <= '0;
			code.pattern <= '0;
			code.overflow <= 1'b0;
		end else if (done_stb) begin
			// character consumed by the table this cycle, start over
			code.len <= '0;
			code.pattern <= '0;
			code.overflow <= 1'b0;
		end else if (symbol_stb) begin
			if (full) begin
				code.overflow <= 1'b1;	// sticky until done
			end else begin
				code.pattern[code.len] <= symbol;	// next free index
				code.len <= code.len + ONE;
			end
		end
	end

endmodule

//--- source/press_sequencer.sv
`timescale 1ns/1ns

module press_sequencer (
	input logic clk,
	input logic rst_n,
	input morse_pkg::keys_t keys,
	output logic symbol_stb,
	output morse_pkg::symbol_e symbol,
	output logic done_stb
);

	// one pulse state and one wait state per key
	typedef enum logic [2:0] {
		IDLE = 3'd0,
		DOT_PULSE = 3'd1,
		DOT_WAIT = 3'd2,
		DASH_PULSE = 3'd3,
		DASH_WAIT = 3'd4,
		DONE_PULSE = 3'd5,
		DONE_WAIT = 3'd6
	} state_e;

	state_e state_q;
	state_e state_d;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	always_comb begin
		state_d = state_q;	// hold by default
		case (state_q)
			IDLE: begin
				// dot beats dash beats done
				if (keys.dot) begin
					state_d = DOT_PULSE;
				end else if (keys.dash) begin
					state_d = DASH_PULSE;
				end else if (keys.done) begin
					state_d = DONE_PULSE;
				end
			end
			DOT_PULSE: state_d = DOT_WAIT;		// pulse lasts one cycle
			DASH_PULSE: state_d = DASH_WAIT;
			DONE_PULSE: state_d = DONE_WAIT;
			DOT_WAIT: begin
				if (!keys.dot) begin
					state_d = IDLE;
				end
			end
			DASH_WAIT: begin
				if (!keys.dash) begin
					state_d = IDLE;
				end
			end
			DONE_WAIT: begin
				if (!keys.done) begin
					state_d = IDLE;	// released, ready for next key
				end
			end
			default: state_d = IDLE;	// unused encoding 7
		endcase
	end

	// moore outputs, one strobe per press however long it is held
	assign symbol_stb = (state_q == DOT_PULSE) || (state_q == DASH_PULSE);
	assign done_stb = (state_q == DONE_PULSE);

	// only meaningful while symbol_stb is high
	assign symbol = (state_q == DASH_PULSE) ? morse_pkg::DASH : morse_pkg::DOT;

endmodule

//--- source/key_sampler.sv
`timescale 1ns/1ns

module key_sampler #(
	parameter int SYNC_STAGES = 2
) (
	input logic clk,
	input logic rst_n,
	input logic [1:0] button_in,	// active low push buttons
	input logic [3:0] switch_in,	// whole dip switch, only bit 0 is the key
	output morse_pkg::keys_t keys
);

	// per stage bit order is {switch 0, button 1, button 0}
	localparam logic [2:0] RELEASED = 3'b011;	// buttons up, switch low

	logic [SYNC_STAGES-1:0][2:0] sync_q;	// stage 0 faces the pins
	logic [2:0] pins_s;					// last stage, safe to use
	logic press0;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sync_q <= {SYNC_STAGES{RELEASED}};
		end else begin
			sync_q[0] <= {switch_in[0], button_in[1], button_in[0]};
			for (int i = 1; i < SYNC_STAGES; i++) begin
				sync_q[i] <= sync_q[i-1];	// plain shift chain
			end
		end
	end

	assign pins_s = sync_q[SYNC_STAGES-1];
	assign press0 = ~pins_s[0];		// button 0 held

	// the switch picks what button 0 means
	always_comb begin
		keys.dot = press0 & ~pins_s[2];
		keys.dash = press0 & pins_s[2];
		keys.done = ~pins_s[1];
	end

endmodule

//--- source/morse_pkg.sv
package morse_pkg;

	// symbol buffer sizing
	localparam int MAX_SYMBOLS = 5;		// longest code in the table (digits)
	localparam int LEN_W = 3;			// holds 0..MAX_SYMBOLS

	// host side of the register window
	localparam int DATA_W = 8;
	localparam int ADDR_W = 2;

	// one morse element, encoding matches the buffer bit value
	typedef enum logic {
		DOT = 1'b0,
		DASH = 1'b1
	} symbol_e;

	// synchronized key levels, all active high
	typedef struct packed {
		logic dot;		// button 0 with switch 0 low
		logic dash;		// button 0 with switch 0 high
		logic done;		// button 1, closes the character
	} keys_t;

	// collected code, always valid
	typedef struct packed {
		logic [LEN_W-1:0] len;				// symbols received so far
		logic [MAX_SYMBOLS-1:0] pattern;	// first symbol in bit 0
		logic overflow;					// more than MAX_SYMBOLS entered
	} code_t;

	// one host bus cycle
	typedef struct packed {
		logic write;					// single cycle write strobe
		logic [ADDR_W-1:0] address;		// also selects the read mux
		logic [DATA_W-1:0] write_data;
	} host_req_t;

	// register map
	typedef enum logic [ADDR_W-1:0] {
		REG_READY = 2'd0,	// new character flag
		REG_CHAR = 2'd1,	// last decoded ascii character
		REG_SPARE2 = 2'd2,	// reads zero
		REG_SPARE3 = 2'd3	// reads zero
	} reg_addr_e;

	// result for anything that is not in the table
	localparam logic [DATA_W-1:0] UNKNOWN_CHAR = "#";

endpackage
